// File: design/aes_ctrl_pkg.sv
// AES control sequencer shared definitions
// Latencies, round limits, phase encoding and counter types
package aes_ctrl_pkg;

    // Serial key-add/S-box cycles per round
    localparam int serial_lat = 4;
    // S-box pipeline depth
    localparam int sbox_lat = 4;
    // Full round length in cycles
    localparam int round_cycles = serial_lat + sbox_lat;

    // Index of the last full round per key size
    localparam int round_limit_128 = 8;
    localparam int round_limit_256 = 12;

    // Cycle and round counters share one width
    localparam int cnt_w = 4;
    typedef logic [cnt_w-1:0] cnt_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        ph_idle,
        ph_first_sbk,
        ph_round,
        ph_last_round,
        ph_ak_final
    } phase_t;

endpackage

// File: design/aes_xfer_if.sv
// Handshake to sequencer link
// Carries the start decision and the job completion status
`timescale 1ns/1ps

interface aes_xfer_if;

    // New job may start this cycle
    logic start_exec;
    // No result pending, or it is fetched now
    logic out_free;
    // Last cycle of the final key addition
    logic job_done;
    // Sequencer sits in ph_idle
    logic idle;

    modport hs (output start_exec, output out_free, input job_done, input idle);
    modport seq (input start_exec, input out_free, output job_done, output idle);

endinterface

// File: design/aes_phase_if.sv
// Sequencer status bus towards the strobe decoders
// Phase, counters and the job mode latched at acceptance
`timescale 1ns/1ps

interface aes_phase_if import aes_ctrl_pkg::*; (
    input logic clk,
    input logic rst
);

    phase_t phase;
    cnt_t   cnt_fsm;
    cnt_t   cnt_round;
    // Job taken on this edge
    logic   accept;
    // Idle with nothing to start and no result pending
    logic   flush;
    logic   job_inverse;
    logic   job_mode_256;

    modport src (
        output phase, cnt_fsm, cnt_round, accept, flush, job_inverse, job_mode_256
    );
    modport dec (
        input clk, rst,
        input phase, cnt_fsm, cnt_round, accept, flush, job_inverse, job_mode_256
    );

endinterface

// File: design/aes_io_handshake.sv
// Job input/output handshake
// Registered in_ready, sticky result flag and start decision
`timescale 1ns/1ps

module aes_io_handshake (
    input  logic    clk,
    input  logic    rst,
    input  logic    valid_in,
    input  logic    out_ready,
    output logic    in_ready,
    output logic    cipher_valid,
    aes_xfer_if.hs  xfer
);

    logic in_ready_q;
    logic valid_out_q;
    logic cipher_fetch;

    assign cipher_fetch = valid_out_q & out_ready;

    // Result flag set at job end and dropped when fetched
    always_ff @(posedge clk) begin
        if (rst || cipher_fetch) begin
            valid_out_q <= 1'b0;
        end else if (xfer.job_done) begin
            valid_out_q <= 1'b1;
        end
    end

    // Input is sticky, so a job may start before in_ready rises
    // No path from out_ready to in_ready within the cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_q <= 1'b1;
        end else if (xfer.idle) begin
            in_ready_q <= in_ready_q ? ~valid_in : xfer.out_free;
        end else begin
            in_ready_q <= 1'b0;
        end
    end

    assign xfer.out_free   = ~valid_out_q | cipher_fetch;
    assign xfer.start_exec = valid_in & xfer.out_free;

    assign in_ready     = in_ready_q;
    assign cipher_valid = valid_out_q;

    // A job never ends on top of a result still waiting for the consumer
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        xfer.job_done |-> !valid_out_q);

endmodule

// File: design/aes_phase_seq.sv
// AES job phase sequencer
// Phase FSM, cycle and round counters, round limit and latched job mode
`timescale 1ns/1ps

module aes_phase_seq import aes_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inverse,
    input  logic     mode_256,
    output logic     busy,
    output logic     global_init,
    aes_xfer_if.seq  xfer,
    aes_phase_if.src ph
);

    phase_t phase_q;
    phase_t phase_d;
    cnt_t   cnt_fsm_q;
    cnt_t   cnt_round_q;
    cnt_t   round_limit_q;
    logic   job_inverse_q;
    logic   job_mode_256_q;
    logic   idle;
    logic   accept;
    logic   flush;
    logic   in_rounds;
    logic   round_end;
    logic   fak_end;
    logic   last_full_round;

    assign idle      = phase_q == ph_idle;
    assign accept    = idle & xfer.start_exec;
    assign flush     = idle & ~xfer.start_exec & xfer.out_free;
    assign in_rounds = (phase_q == ph_round) | (phase_q == ph_last_round);
    // Round ends after serial and S-box latency cycles
    assign round_end = cnt_fsm_q == cnt_t'(round_cycles - 1);
    // Final key addition takes one serial pass
    assign fak_end   = cnt_fsm_q == cnt_t'(serial_lat - 1);
    assign last_full_round = cnt_round_q == round_limit_q;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            ph_idle: begin
                if (accept) begin
                    phase_d = ph_first_sbk;
                end
            end
            // One cycle sending the last key column to the S-box
            ph_first_sbk: phase_d = ph_round;
            ph_round: begin
                if (round_end && last_full_round) begin
                    phase_d = ph_last_round;
                end
            end
            ph_last_round: begin
                if (round_end) begin
                    phase_d = ph_ak_final;
                end
            end
            ph_ak_final: begin
                if (fak_end) begin
                    phase_d = ph_idle;
                end
            end
            default: phase_d = ph_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q       <= ph_idle;
            cnt_fsm_q     <= '0;
            cnt_round_q   <= '0;
            round_limit_q <= '0;
        end else begin
            phase_q <= phase_d;
            // Cycle counter restarts at every round boundary
            if (idle || phase_q == ph_first_sbk || (in_rounds && round_end)) begin
                cnt_fsm_q <= '0;
            end else begin
                cnt_fsm_q <= cnt_fsm_q + 1'b1;
            end
            // Round index rests one past the limit from the last round on
            if (idle) begin
                cnt_round_q <= '0;
            end else if (phase_q == ph_round && round_end) begin
                cnt_round_q <= cnt_round_q + 1'b1;
            end
            // Limit follows the key size of the running job
            if (phase_q == ph_first_sbk) begin
                round_limit_q <= job_mode_256_q ? cnt_t'(round_limit_256)
                                                : cnt_t'(round_limit_128);
            end
        end
    end

    // Job mode held for the whole run
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            job_inverse_q  <= 1'b0;
            job_mode_256_q <= 1'b0;
        end else if (accept) begin
            job_inverse_q  <= inverse;
            job_mode_256_q <= mode_256;
        end
    end

    assign ph.phase        = phase_q;
    assign ph.cnt_fsm      = cnt_fsm_q;
    assign ph.cnt_round    = cnt_round_q;
    assign ph.accept       = accept;
    assign ph.flush        = flush;
    assign ph.job_inverse  = job_inverse_q;
    assign ph.job_mode_256 = job_mode_256_q;

    assign xfer.idle     = idle;
    assign xfer.job_done = (phase_q == ph_ak_final) & fak_end;

    assign busy        = ~idle;
    assign global_init = accept;

    a_cnt_fsm_range: assert property (@(posedge clk) disable iff (rst)
        cnt_fsm_q <= cnt_t'(round_cycles - 1));

    // Round index may reach one past the limit only after the last round
    a_cnt_round_range: assert property (@(posedge clk) disable iff (rst)
        cnt_round_q <= round_limit_q + 1'b1);

endmodule

// File: design/aes_state_ctrl.sv
// State datapath strobe decoder
// Enables, loop and MixColumns controls and key-add enables
`timescale 1ns/1ps

module aes_state_ctrl import aes_ctrl_pkg::*; (
    aes_phase_if.dec ph,
    input  logic     inverse,
    output logic     state_enable,
    output logic     state_init,
    output logic     state_en_mc,
    output logic     state_en_loop,
    output logic     state_en_loop_r0,
    output logic     state_en_sb_inverse,
    output logic     state_bypass_mc_inverse,
    output logic     state_en_to_sb_inverse,
    output logic     enable_key_add,
    output logic     enable_key_add_inverse
);

    logic inv;
    logic in_rounds;
    logic in_aksb;
    logic ak_window;

    // Direction of the incoming job is already valid on the accept cycle
    assign inv       = ph.accept ? inverse : ph.job_inverse;
    assign in_rounds = (ph.phase == ph_round) | (ph.phase == ph_last_round);
    assign in_aksb   = ph.cnt_fsm < cnt_t'(serial_lat);
    assign ak_window = (in_rounds & in_aksb) | (ph.phase == ph_ak_final);

    // Load fresh input on a start and clear the core when nothing follows
    assign state_init = ph.accept | ph.flush;

    // Frozen while the S-box returns key material
    assign state_enable = ph.accept | ph.flush | (ph.phase == ph_ak_final)
                        | (in_rounds & (ph.cnt_fsm != cnt_t'(sbox_lat - 1)));

    // Forward MixColumns only and never in the last round
    assign state_en_mc = ~ph.job_inverse & (ph.phase == ph_round);

    // Row 0 loops during key add; decryption keeps the other rows looping
    assign state_en_loop_r0 = ak_window;
    assign state_en_loop    = inv | ak_window;

    assign state_en_sb_inverse     = ph.job_inverse & in_rounds & ~in_aksb;
    assign state_bypass_mc_inverse = ph.job_inverse & (ph.phase == ph_round) & in_aksb
                                   & (ph.cnt_round == '0);
    assign state_en_to_sb_inverse  = inv;

    assign enable_key_add         = ak_window & ~ph.job_inverse;
    assign enable_key_add_inverse = ak_window & ph.job_inverse;

    // Key add runs in bursts of one serial pass in a single direction
    a_key_add_excl: assert property (@(posedge ph.clk) disable iff (ph.rst)
        $rose(enable_key_add || enable_key_add_inverse)
        |-> (enable_key_add ^ enable_key_add_inverse) [*serial_lat]);

endmodule

// File: design/aes_key_ctrl.sv
// Key holder strobe decoder
// Enable, loop and buffer controls for AES-128 and AES-256 schedules
`timescale 1ns/1ps

module aes_key_ctrl import aes_ctrl_pkg::*; (
    aes_phase_if.dec ph,
    input  logic     mode_256,
    output logic     kh_init,
    output logic     kh_enable,
    output logic     kh_loop,
    output logic     kh_add_from_sb,
    output logic     kh_enable_buffer_from_sbox,
    output logic     kh_rst_buffer_from_sbox,
    output logic     kh_last_key_pre_valid,
    output logic     kh_disable_rot_rcon,
    output logic     kh_enable_pipe_high,
    output logic     kh_feedback_from_high,
    output logic     kh_col7_to_sb,
    output logic     kh_mode_256
);

    logic first_sbk;
    logic in_rounds;
    logic last_cycle;
    logic key_from_sbox;
    logic key_update;
    logic key_shift;
    logic loop_cycle;

    assign first_sbk  = ph.phase == ph_first_sbk;
    assign in_rounds  = (ph.phase == ph_round) | (ph.phase == ph_last_round);
    assign last_cycle = ph.cnt_fsm == cnt_t'(round_cycles - 1);
    // S-box output carries key material on this cycle
    assign key_from_sbox = ph.cnt_fsm == cnt_t'(sbox_lat - 1);
    // Key update spans cycles 3 to 6
    assign key_update = (ph.cnt_fsm >= cnt_t'(sbox_lat - 1))
                      & (ph.cnt_fsm < cnt_t'(sbox_lat + 3));
    // New material shifts through the first column in cycles 4 to 7
    assign key_shift  = in_rounds & (ph.cnt_fsm > cnt_t'(sbox_lat - 1));
    // Key bytes used by the key add, plus the cycle priming the next schedule step
    assign loop_cycle = (ph.cnt_fsm < cnt_t'(serial_lat - 1)) | last_cycle;

    assign kh_init = ph.accept | ph.flush;

    // Lower half runs on every round cycle
    assign kh_enable = ph.accept | ph.flush | first_sbk | in_rounds
                     | (ph.phase == ph_ak_final);

    // AES-256 also holds the last-round key update for decryption
    assign kh_loop = first_sbk | (ph.phase == ph_ak_final)
                   | ((ph.phase == ph_round) & loop_cycle)
                   | ((ph.phase == ph_last_round) & (ph.job_mode_256 | loop_cycle));

    assign kh_add_from_sb = in_rounds & key_from_sbox;

    // Decryption buffer for the last key column
    assign kh_rst_buffer_from_sbox    = first_sbk
                                      | (in_rounds & (ph.cnt_fsm == cnt_t'(round_cycles - 2)));
    assign kh_enable_buffer_from_sbox = first_sbk | (ph.job_inverse & in_rounds & key_update);

    // First cycle of the final key add sees the last round key
    assign kh_last_key_pre_valid = (ph.phase == ph_last_round) & last_cycle;

    // AES-256 skips RotWord and RCON on odd rounds
    assign kh_disable_rot_rcon = ph.job_mode_256 & in_rounds & ph.cnt_round[0];

    // Upper half loads with the input key, then follows the shift
    assign kh_enable_pipe_high   = ph.accept ? mode_256 : (ph.job_mode_256 & key_shift);
    assign kh_feedback_from_high = ph.job_mode_256 & key_shift;
    assign kh_col7_to_sb         = ph.job_mode_256 & first_sbk;
    assign kh_mode_256           = ph.job_mode_256;

endmodule

// File: design/aes_sbox_ctrl.sv
// S-box and RCON strobe decoder
// S-box valid, direction and input select, RCON control and randomness request
`timescale 1ns/1ps

module aes_sbox_ctrl import aes_ctrl_pkg::*; (
    aes_phase_if.dec ph,
    input  logic     inverse,
    input  logic     start_exec,
    output logic     sbox_valid_in,
    output logic     sbox_inverse,
    output logic     feed_sb_key,
    output logic     rcon_rst,
    output logic     rcon_mode_256,
    output logic     rcon_update,
    output logic     rcon_inverse,
    output logic     pre_need_rnd
);

    logic first_sbk;
    logic in_rounds;
    logic last_cycle;

    assign first_sbk  = ph.phase == ph_first_sbk;
    assign in_rounds  = (ph.phase == ph_round) | (ph.phase == ph_last_round);
    assign last_cycle = ph.cnt_fsm == cnt_t'(round_cycles - 1);

    // Key column enters the S-box on the first cycle and at each round end
    assign feed_sb_key = first_sbk | (in_rounds & last_cycle);

    // Key-add results during serial cycles, key column before the next round
    assign sbox_valid_in = first_sbk
                         | (in_rounds & (ph.cnt_fsm < cnt_t'(serial_lat)))
                         | ((ph.phase == ph_round) & last_cycle);

    // Key schedule always uses the forward S-box
    assign sbox_inverse = ph.job_inverse & ~feed_sb_key;

    assign rcon_rst      = first_sbk;
    assign rcon_mode_256 = ph.job_mode_256;
    assign rcon_inverse  = ph.accept ? inverse : ph.job_inverse;

    // AES-256 steps on odd rounds in encryption and even rounds in decryption
    assign rcon_update = (ph.phase == ph_round) & last_cycle
                       & (~ph.job_mode_256 | (ph.job_inverse ^ ph.cnt_round[0]));

    // Masking randomness needed unless idle with no start
    assign pre_need_rnd = ~((ph.phase == ph_idle) & ~start_exec);

endmodule

// File: design/aes_ctrl_top.sv
// Control sequencer of a 32-bit serial masked AES core
// Job handshake, phase sequencing and per-cycle datapath strobes
`timescale 1ns/1ps

module aes_ctrl_top (
    input  logic clk,
    input  logic rst,
    input  logic inverse,
    input  logic mode_256,
    input  logic valid_in,
    input  logic out_ready,
    output logic in_ready,
    output logic cipher_valid,
    output logic busy,
    output logic global_init,
    output logic pre_need_rnd,
    // State datapath
    output logic state_enable,
    output logic state_init,
    output logic state_en_mc,
    output logic state_en_loop,
    output logic state_en_loop_r0,
    output logic state_en_sb_inverse,
    output logic state_bypass_mc_inverse,
    output logic state_en_to_sb_inverse,
    output logic enable_key_add,
    output logic enable_key_add_inverse,
    // Key holder
    output logic kh_init,
    output logic kh_enable,
    output logic kh_loop,
    output logic kh_add_from_sb,
    output logic kh_enable_buffer_from_sbox,
    output logic kh_rst_buffer_from_sbox,
    output logic kh_last_key_pre_valid,
    output logic kh_disable_rot_rcon,
    output logic kh_enable_pipe_high,
    output logic kh_feedback_from_high,
    output logic kh_col7_to_sb,
    output logic kh_mode_256,
    // S-box and RCON
    output logic sbox_valid_in,
    output logic sbox_inverse,
    output logic feed_sb_key,
    output logic rcon_rst,
    output logic rcon_mode_256,
    output logic rcon_update,
    output logic rcon_inverse
);

    // Internal buses, named as the block ports so implicit connections apply
    aes_xfer_if  xfer ();
    aes_phase_if ph (.clk(clk), .rst(rst));

    // valid/ready handshake and result holding
    aes_io_handshake u_handshake (.*);

    // Phase FSM and counters
    aes_phase_seq u_phase_seq (.*);

    // Strobe decoders
    aes_state_ctrl u_state_ctrl (.*);

    aes_key_ctrl u_key_ctrl (.*);

    aes_sbox_ctrl u_sbox_ctrl (
        .start_exec(xfer.start_exec),
        .*
    );

endmodule

// File: sim/tb_aes_ctrl.sv
// Testbench for the AES control sequencer
// Runs jobs in all modes and checks latency, strobe counts and back-pressure
`timescale 1ns/1ps

module tb_aes_ctrl;

    logic clk;
    logic rst;
    logic inverse;
    logic mode_256;
    logic valid_in;
    logic out_ready;
    logic in_ready;
    logic cipher_valid;
    logic busy;
    logic global_init;
    logic pre_need_rnd;
    logic state_enable;
    logic state_init;
    logic state_en_mc;
    logic state_en_loop;
    logic state_en_loop_r0;
    logic state_en_sb_inverse;
    logic state_bypass_mc_inverse;
    logic state_en_to_sb_inverse;
    logic enable_key_add;
    logic enable_key_add_inverse;
    logic kh_init;
    logic kh_enable;
    logic kh_loop;
    logic kh_add_from_sb;
    logic kh_enable_buffer_from_sbox;
    logic kh_rst_buffer_from_sbox;
    logic kh_last_key_pre_valid;
    logic kh_disable_rot_rcon;
    logic kh_enable_pipe_high;
    logic kh_feedback_from_high;
    logic kh_col7_to_sb;
    logic kh_mode_256;
    logic sbox_valid_in;
    logic sbox_inverse;
    logic feed_sb_key;
    logic rcon_rst;
    logic rcon_mode_256;
    logic rcon_update;
    logic rcon_inverse;

    // Mode of the job last handed to the DUT
    logic job_inv;
    logic job_256;
    int   errors;
    int   test_err_base;
    int   tests_run;
    int   tests_failed;
    int   cyc;
    int   accept_cyc;
    int   fetch_cyc;
    int   stall;
    integer seed;
    // Strobe counts over one job
    int   n_mc;
    int   n_rcon;
    int   n_ginit;
    int   n_aki;
    int   n_ak;
    int   n_bypass;

    aes_ctrl_top dut_i (.*);

    always #10 clk = ~clk;

    // Edge counter and strobe counts sampled just before each edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (state_en_mc) n_mc <= n_mc + 1;
        if (rcon_update) n_rcon <= n_rcon + 1;
        if (global_init) n_ginit <= n_ginit + 1;
        if (enable_key_add_inverse) n_aki <= n_aki + 1;
        if (enable_key_add) n_ak <= n_ak + 1;
        if (state_bypass_mc_inverse) n_bypass <= n_bypass + 1;
    end

    // Result waits untouched while the consumer stalls
    a_result_held: assert property (@(posedge clk) disable iff (rst)
        cipher_valid && !out_ready |=> cipher_valid)
        else begin
            $display("cipher_valid dropped while out_ready was low");
            errors++;
        end

    // No new job and no randomness request behind a pending result
    a_hold_quiet: assert property (@(posedge clk) disable iff (rst)
        cipher_valid && !out_ready |-> !busy && !pre_need_rnd)
        else begin
            $display("busy or pre_need_rnd high while a result was pending");
            errors++;
        end

    // Job end raises the result flag on the same edge
    a_done_valid: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> cipher_valid)
        else begin
            $display("busy fell without cipher_valid rising");
            errors++;
        end

    a_no_rot_128: assert property (@(posedge clk) disable iff (rst)
        busy && !job_256 |-> !kh_disable_rot_rcon)
        else begin
            $display("kh_disable_rot_rcon high during an AES-128 job");
            errors++;
        end

    // Decryption uses only the inverse key add and no forward MixColumns
    a_dec_fwd_off: assert property (@(posedge clk) disable iff (rst)
        busy && job_inv |-> !enable_key_add && !state_en_mc)
        else begin
            $display("forward key add or MixColumns active in decryption");
            errors++;
        end

    a_enc_inv_off: assert property (@(posedge clk) disable iff (rst)
        busy && !job_inv |-> !enable_key_add_inverse && !state_bypass_mc_inverse)
        else begin
            $display("inverse key add or MixColumns bypass active in encryption");
            errors++;
        end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_counts();
        n_mc = 0;
        n_rcon = 0;
        n_ginit = 0;
        n_aki = 0;
        n_ak = 0;
        n_bypass = 0;
    endtask

    // Present a job and hold valid_in up until acceptance
    task automatic issue_job(input logic inv, input logic m256);
        @(posedge clk);
        #2;
        inverse  = inv;
        mode_256 = m256;
        valid_in = 1'b1;
        job_inv  = inv;
        job_256  = m256;
    endtask

    // Acceptance edge is the one after which busy is first seen high
    task automatic wait_accept();
        logic found;
        found = 1'b0;
        for (int n = 0; n < 200 && !found; n++) begin
            @(negedge clk);
            found = busy;
        end
        if (!found) begin
            $display("no job was accepted within 200 cycles");
            errors++;
        end
        accept_cyc = cyc;
        @(posedge clk);
        #2;
        valid_in = 1'b0;
    endtask

    task automatic wait_result(input int exp_lat);
        logic found;
        found = 1'b0;
        for (int n = 0; n < 200 && !found; n++) begin
            @(negedge clk);
            found = cipher_valid;
        end
        if (!found) begin
            $display("cipher_valid did not rise within 200 cycles");
            errors++;
        end else begin
            check_value("latency", cyc - accept_cyc, exp_lat);
            check_value("busy", busy, 1'b0);
        end
    endtask

    task automatic run_job(input logic inv, input logic m256, input int exp_lat);
        clear_counts();
        issue_job(inv, m256);
        wait_accept();
        wait_result(exp_lat);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("%-16s ok", name);
        end else begin
            tests_failed++;
            $display("%-16s FAILED with %0d errors", name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inverse = 1'b0;
        mode_256 = 1'b0;
        valid_in = 1'b0;
        out_ready = 1'b1;
        job_inv = 1'b0;
        job_256 = 1'b0;
        errors = 0;
        test_err_base = 0;
        tests_run = 0;
        tests_failed = 0;
        cyc = 0;
        accept_cyc = 0;
        fetch_cyc = 0;
        seed = 81;
        clear_counts();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle with nothing pending, so only the flush strobes are up
        @(negedge clk);
        check_value("in_ready", in_ready, 1'b1);
        check_value("busy", busy, 1'b0);
        check_value("cipher_valid", cipher_valid, 1'b0);
        check_value("global_init", global_init, 1'b0);
        check_value("flush_strobes", {state_init, state_enable, kh_init, kh_enable}, 4'hf);
        check_value("idle_strobes", {state_en_mc, state_en_loop, state_en_loop_r0,
            state_en_sb_inverse, state_bypass_mc_inverse, state_en_to_sb_inverse,
            enable_key_add, enable_key_add_inverse, kh_loop, kh_add_from_sb,
            kh_enable_buffer_from_sbox, kh_rst_buffer_from_sbox, kh_last_key_pre_valid,
            kh_disable_rot_rcon, kh_enable_pipe_high, kh_feedback_from_high,
            kh_col7_to_sb, kh_mode_256, sbox_valid_in, sbox_inverse, feed_sb_key,
            rcon_rst, rcon_mode_256, rcon_update, rcon_inverse, pre_need_rnd}, 0);
        end_test("after_reset");

        // 9 rounds of MixColumns and one RCON step per round
        run_job(1'b0, 1'b0, 85);
        check_value("state_en_mc count", n_mc, 72);
        check_value("rcon_update count", n_rcon, 9);
        check_value("global_init count", n_ginit, 1);
        end_test("aes128_encrypt");

        // RCON steps on odd rounds in encryption and on even rounds in decryption
        run_job(1'b0, 1'b1, 117);
        check_value("rcon_update count", n_rcon, 6);
        run_job(1'b1, 1'b1, 117);
        check_value("rcon_update count", n_rcon, 7);
        end_test("aes256");

        run_job(1'b1, 1'b0, 85);
        check_value("enable_key_add_inverse count", n_aki, 44);
        check_value("enable_key_add count", n_ak, 0);
        check_value("state_bypass_mc_inverse count", n_bypass, 4);
        check_value("state_en_mc count", n_mc, 0);
        end_test("aes128_decrypt");

        // Result held back with the next job queued behind it
        @(posedge clk);
        #2;
        out_ready = 1'b0;
        run_job(1'b0, 1'b0, 85);
        issue_job(1'b1, 1'b1);
        stall = 3 + ({$random(seed)} % 12);
        repeat (stall) begin
            @(negedge clk);
            check_value("cipher_valid", cipher_valid, 1'b1);
            check_value("busy", busy, 1'b0);
            check_value("pre_need_rnd", pre_need_rnd, 1'b0);
        end
        @(posedge clk);
        #2;
        out_ready = 1'b1;
        // Result is fetched on the next rising edge
        fetch_cyc = cyc + 1;
        // Fetch and acceptance share one edge
        wait_accept();
        check_value("accept edge", accept_cyc, fetch_cyc);
        check_value("cipher_valid", cipher_valid, 1'b0);
        wait_result(117);
        end_test("back_pressure");

        $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: aes_ctrl_top.f
design/aes_ctrl_pkg.sv
design/aes_xfer_if.sv
design/aes_phase_if.sv
design/aes_io_handshake.sv
design/aes_phase_seq.sv
design/aes_state_ctrl.sv
design/aes_key_ctrl.sv
design/aes_sbox_ctrl.sv
design/aes_ctrl_top.sv
sim/tb_aes_ctrl.sv
